//--- build.f
design/mapper_pkg.sv
design/bus_sampler.sv
design/bank_regs.sv
design/addr_decode.sv
design/flash_emu.sv
design/cart_mapper.sv
bench/tb_cart_mapper.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_cart_mapper
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "run passed"; \
	else \
		echo "run did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_cart_mapper.sv
module tb_cart_mapper;
    timeunit 1ns;
    timeprecision 1ps;

    typedef enum logic [1:0] {
        op_io_wr,
        op_io_rd,
        op_mem_wr,
        op_mem_rd
    } op_t;

    // exp_sel holds {psram1_sel_n, psram2_sel_n, sram_sel_n}
    typedef struct packed {
        op_t                   op;
        mapper_pkg::reg_addr_t addr;
        mapper_pkg::byte_t     data;
        logic                  exp_oe;
        mapper_pkg::byte_t     exp_dout;
        mapper_pkg::addr_ext_t exp_ext;
        logic [2:0]            exp_sel;
    } row_t;

    logic                  SClk;
    logic                  reset;
    logic                  sel_n;
    logic                  oe_n;
    logic                  we_n;
    logic                  io_n;
    logic [3:0]            addr_hi;
    logic [3:0]            addr_lo;
    mapper_pkg::byte_t     data_in;
    mapper_pkg::byte_t     data_out;
    logic                  data_oe;
    mapper_pkg::addr_ext_t addr_ext;
    logic                  psram1_sel_n;
    logic                  psram2_sel_n;
    logic                  sram_sel_n;

    row_t            table_q[$];
    int              mismatches;
    int              tests_run;
    int              tests_failed;
    longint unsigned watchdog_ns;
    logic            table_ready;

    cart_mapper dut0 (
        .SClk(SClk), .reset(reset),
        .sel_n(sel_n), .oe_n(oe_n), .we_n(we_n), .io_n(io_n),
        .addr_hi(addr_hi), .addr_lo(addr_lo), .data_in(data_in),
        .data_out(data_out), .data_oe(data_oe), .addr_ext(addr_ext),
        .psram1_sel_n(psram1_sel_n), .psram2_sel_n(psram2_sel_n), .sram_sel_n(sram_sel_n)
    );

    initial begin
        SClk = 1'b0;
        forever #10 SClk = ~SClk;
    end

    task automatic check_byte(input string name, input mapper_pkg::byte_t got,
                              input mapper_pkg::byte_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_addr_ext(input string name, input mapper_pkg::addr_ext_t got,
                                  input mapper_pkg::addr_ext_t exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %02h expected %02h", $time, name, got, exp);
            mismatches++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t ns: %s got %b expected %b", $time, name, got, exp);
            mismatches++;
        end
    endtask

    function automatic string op_name(input op_t op);
        case (op)
            op_io_wr:  return "io write ";
            op_io_rd:  return "io read  ";
            op_mem_wr: return "mem write";
            default:   return "mem read ";
        endcase
    endfunction

    task automatic finish_test(input string what);
        tests_run++;
        if (mismatches != 0) begin
            tests_failed++;
        end
        $display("%s: %s", what, (mismatches == 0) ? "ok" : "mismatch");
    endtask

    task automatic add_row(input op_t op, input mapper_pkg::reg_addr_t addr,
                           input mapper_pkg::byte_t data, input logic exp_oe,
                           input mapper_pkg::byte_t exp_dout,
                           input mapper_pkg::addr_ext_t exp_ext, input logic [2:0] exp_sel);
        row_t r;
        r = '{op, addr, data, exp_oe, exp_dout, exp_ext, exp_sel};
        table_q.push_back(r);
    endtask

    task automatic load_table();
        // reset values, linear area pages give the io addr_ext
        add_row(op_io_rd,  8'hC2, 8'h00, 1'b1, 8'hFF, 7'h7C, 3'b111);
        add_row(op_io_rd,  8'hD3, 8'h00, 1'b1, 8'h03, 7'h7D, 3'b111);
        add_row(op_io_rd,  8'hE4, 8'h00, 1'b1, 8'hFF, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE5, 8'h00, 1'b1, 8'hFF, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE2, 8'h00, 1'b1, 8'h54, 7'h7E, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b0, 8'h00, 7'h7F, 3'b111);
        // banking, high halves cleared first so the page lands in psram
        add_row(op_io_wr,  8'hD3, 8'h00, 1'b0, 8'h00, 7'h7D, 3'b111);
        add_row(op_io_wr,  8'hC2, 8'h05, 1'b0, 8'h00, 7'h7C, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b0, 8'h00, 7'h05, 3'b011);
        add_row(op_io_wr,  8'hD4, 8'h80, 1'b0, 8'h00, 7'h7D, 3'b111);
        add_row(op_io_wr,  8'hD5, 8'h00, 1'b0, 8'h00, 7'h7D, 3'b111);
        add_row(op_mem_rd, 8'h30, 8'h00, 1'b0, 8'h00, 7'h00, 3'b101);
        // extension gating
        add_row(op_io_wr,  8'hE2, 8'h50, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE2, 8'h00, 1'b1, 8'h50, 7'h7E, 3'b111);
        add_row(op_io_wr,  8'hE4, 8'h12, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE4, 8'h00, 1'b1, 8'hFF, 7'h7E, 3'b111);
        add_row(op_io_wr,  8'hE2, 8'h04, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE2, 8'h00, 1'b1, 8'h50, 7'h7E, 3'b111);
        add_row(op_io_wr,  8'hE2, 8'hFD, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE2, 8'h00, 1'b1, 8'h54, 7'h7E, 3'b111);
        // bank mask, rom_mask 103 also trims the linear page to 102
        add_row(op_io_wr,  8'hE4, 8'h03, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b0, 8'h00, 7'h01, 3'b011);
        add_row(op_io_wr,  8'hE5, 8'hFD, 1'b0, 8'h00, 7'h02, 3'b111);
        add_row(op_io_rd,  8'hE5, 8'h00, 1'b1, 8'hFD, 7'h02, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b0, 8'h00, 7'h05, 3'b011);
        add_row(op_io_wr,  8'hE4, 8'hFF, 1'b0, 8'h00, 7'h02, 3'b111);
        // sram, then self-flash moves the RAM area to psram1
        add_row(op_io_wr,  8'hC1, 8'h02, 1'b0, 8'h00, 7'h7C, 3'b111);
        add_row(op_io_wr,  8'hD1, 8'h00, 1'b0, 8'h00, 7'h7D, 3'b111);
        add_row(op_mem_wr, 8'h10, 8'h5A, 1'b0, 8'h00, 7'h02, 3'b110);
        add_row(op_io_wr,  8'hCE, 8'h01, 1'b0, 8'h00, 7'h7C, 3'b111);
        add_row(op_mem_wr, 8'h10, 8'h5A, 1'b0, 8'h00, 7'h02, 3'b011);
        // flash emulation on a rom0 page in psram1
        add_row(op_io_wr,  8'hE6, 8'h04, 1'b0, 8'h00, 7'h7E, 3'b111);
        add_row(op_io_rd,  8'hE6, 8'h00, 1'b1, 8'h04, 7'h7E, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'h11, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'hAA, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'h55, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'hA0, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'h33, 1'b0, 8'h00, 7'h05, 3'b011);
        add_row(op_mem_wr, 8'h20, 8'hAA, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'h55, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_wr, 8'h20, 8'h30, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b1, 8'hFF, 7'h05, 3'b111);
        // a new unlock from erase lets reads through again
        add_row(op_mem_wr, 8'h20, 8'hAA, 1'b0, 8'h00, 7'h05, 3'b111);
        add_row(op_mem_rd, 8'h20, 8'h00, 1'b0, 8'h00, 7'h05, 3'b011);
    endtask

    // called on a rising edge, returns on the rising edge after the idle cycles
    task automatic run_row(input int idx, input row_t r);
        logic is_read;
        logic is_mem;
        is_read = (r.op == op_io_rd) || (r.op == op_mem_rd);
        is_mem  = (r.op == op_mem_wr) || (r.op == op_mem_rd);
        mismatches = 0;
        sel_n   <= 1'b0;
        io_n    <= is_mem;
        addr_hi <= r.addr[7:4];
        addr_lo <= r.addr[3:0];
        data_in <= r.data;
        if (is_read) begin
            oe_n <= 1'b0;
        end else begin
            we_n <= 1'b0;
        end
        repeat (2) @(posedge SClk);
        // third low cycle
        @(negedge SClk);
        check_bit("data_oe", data_oe, r.exp_oe);
        if (r.exp_oe) begin
            check_byte("data_out", data_out, r.exp_dout);
        end
        check_addr_ext("addr_ext", addr_ext, r.exp_ext);
        check_bit("psram1_sel_n", psram1_sel_n, r.exp_sel[2]);
        check_bit("psram2_sel_n", psram2_sel_n, r.exp_sel[1]);
        check_bit("sram_sel_n", sram_sel_n, r.exp_sel[0]);
        @(posedge SClk);
        sel_n <= 1'b1;
        oe_n  <= 1'b1;
        we_n  <= 1'b1;
        repeat (3) @(posedge SClk);
        finish_test($sformatf("row %0d %s addr %02h data %02h", idx, op_name(r.op),
                              r.addr, r.data));
    endtask

    initial begin
        reset        = 1'b1;
        sel_n        = 1'b1;
        oe_n         = 1'b1;
        we_n         = 1'b1;
        io_n         = 1'b1;
        addr_hi      = 4'h0;
        addr_lo      = 4'h0;
        data_in      = 8'h00;
        mismatches   = 0;
        tests_run    = 0;
        tests_failed = 0;
        table_ready  = 1'b0;
        load_table();
        watchdog_ns = (longint'(table_q.size()) * 10 + 8) * 20 * 2;
        table_ready = 1'b1;

        // a register read held across reset must not reach the bus
        @(posedge SClk);
        sel_n   <= 1'b0;
        oe_n    <= 1'b0;
        io_n    <= 1'b0;
        addr_hi <= 4'hC;
        addr_lo <= 4'h2;
        repeat (6) @(posedge SClk);
        @(negedge SClk);
        check_bit("data_oe", data_oe, 1'b0);
        check_bit("psram1_sel_n", psram1_sel_n, 1'b1);
        check_bit("psram2_sel_n", psram2_sel_n, 1'b1);
        check_bit("sram_sel_n", sram_sel_n, 1'b1);
        @(posedge SClk);
        reset <= 1'b0;
        // first cycle after reset still shows the reset samples
        @(negedge SClk);
        check_bit("data_oe", data_oe, 1'b0);
        check_bit("psram1_sel_n", psram1_sel_n, 1'b1);
        check_bit("psram2_sel_n", psram2_sel_n, 1'b1);
        check_bit("sram_sel_n", sram_sel_n, 1'b1);
        finish_test("selects idle in reset");
        @(posedge SClk);
        sel_n <= 1'b1;
        oe_n  <= 1'b1;
        io_n  <= 1'b1;
        repeat (3) @(posedge SClk);

        foreach (table_q[i]) begin
            run_row(i, table_q[i]);
        end

        $display("tests run %0d, passed %0d, failed %0d", tests_run,
                 tests_run - tests_failed, tests_failed);
        if (tests_failed == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        wait (table_ready);
        #(watchdog_ns);
        $display("watchdog expired before the table was done");
        $display("Simulation failed");
        $finish;
    end

endmodule

//--- design/cart_mapper.sv
module cart_mapper (
    input  logic                  SClk,
    input  logic                  reset,
    input  logic                  sel_n,
    input  logic                  oe_n,
    input  logic                  we_n,
    input  logic                  io_n,
    input  logic [3:0]            addr_hi,
    input  logic [3:0]            addr_lo,
    input  mapper_pkg::byte_t     data_in,
    output mapper_pkg::byte_t     data_out,
    output logic                  data_oe,
    output mapper_pkg::addr_ext_t addr_ext,
    output logic                  psram1_sel_n,
    output logic                  psram2_sel_n,
    output logic                  sram_sel_n
);

    logic s_sel_n, s_oe_n, s_we_n, s_io_n;
    logic [3:0] s_addr_hi;
    logic io_wr, mem_wr;
    mapper_pkg::reg_addr_t s_reg_addr, wr_addr;
    mapper_pkg::byte_t wr_data, linear_bank, reg_data, status;
    mapper_pkg::bank_t ram_bank, rom0_bank, rom1_bank;
    mapper_pkg::rom_page_t rom_mask;
    mapper_pkg::ram_page_t ram_mask;
    logic mask_rom0, mask_rom1, mask_ram;
    logic self_flash, sram_enable, flash_emu_enable, reg_hit;
    logic psram1_hit, psram2_hit;
    logic pass_read, pass_write, catch_read;

    bus_sampler sampler0 (
        .SClk(SClk), .reset(reset),
        .sel_n(sel_n), .oe_n(oe_n), .we_n(we_n), .io_n(io_n),
        .addr_hi(addr_hi), .addr_lo(addr_lo), .data_in(data_in),
        .s_sel_n(s_sel_n), .s_oe_n(s_oe_n), .s_we_n(s_we_n), .s_io_n(s_io_n),
        .s_reg_addr(s_reg_addr), .s_addr_hi(s_addr_hi), .s_data(),
        .io_wr(io_wr), .mem_wr(mem_wr), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    bank_regs regs0 (
        .SClk(SClk), .reset(reset),
        .io_wr(io_wr), .wr_addr(wr_addr), .wr_data(wr_data), .s_reg_addr(s_reg_addr),
        .linear_bank(linear_bank), .ram_bank(ram_bank),
        .rom0_bank(rom0_bank), .rom1_bank(rom1_bank),
        .rom_mask(rom_mask), .ram_mask(ram_mask),
        .mask_rom0(mask_rom0), .mask_rom1(mask_rom1), .mask_ram(mask_ram),
        .self_flash(self_flash), .sram_enable(sram_enable),
        .flash_emu_enable(flash_emu_enable), .reg_hit(reg_hit), .reg_data(reg_data)
    );

    addr_decode decode0 (
        .linear_bank(linear_bank), .ram_bank(ram_bank),
        .rom0_bank(rom0_bank), .rom1_bank(rom1_bank),
        .rom_mask(rom_mask), .ram_mask(ram_mask),
        .mask_rom0(mask_rom0), .mask_rom1(mask_rom1), .mask_ram(mask_ram),
        .self_flash(self_flash), .sram_enable(sram_enable),
        .s_addr_hi(s_addr_hi), .s_sel_n(s_sel_n), .s_oe_n(s_oe_n),
        .s_we_n(s_we_n), .s_io_n(s_io_n),
        .pass_read(pass_read), .pass_write(pass_write),
        .psram1_hit(psram1_hit), .psram2_hit(psram2_hit), .addr_ext(addr_ext),
        .psram1_sel_n(psram1_sel_n), .psram2_sel_n(psram2_sel_n), .sram_sel_n(sram_sel_n)
    );

    flash_emu flash0 (
        .SClk(SClk), .reset(reset),
        .mem_wr(mem_wr), .wr_data(wr_data),
        .psram1_hit(psram1_hit), .psram2_hit(psram2_hit),
        .flash_emu_enable(flash_emu_enable),
        .pass_read(pass_read), .pass_write(pass_write),
        .catch_read(catch_read), .status(status)
    );

    // the cartridge drives the bus for register reads and emulated flash status
    assign data_oe  = ~s_sel_n & ~s_oe_n & ((~s_io_n & reg_hit) | (s_io_n & catch_read));
    assign data_out = s_io_n ? status : reg_data;

endmodule

//--- design/flash_emu.sv
module flash_emu (
    input  logic              SClk,
    input  logic              reset,
    input  logic              mem_wr,
    input  mapper_pkg::byte_t wr_data,
    input  logic              psram1_hit,
    input  logic              psram2_hit,
    input  logic              flash_emu_enable,
    output logic              pass_read,
    output logic              pass_write,
    output logic              catch_read,
    output mapper_pkg::byte_t status
);

    mapper_pkg::flash_state_t state;
    logic psram_hit;

    assign psram_hit = psram1_hit | psram2_hit;

    always_ff @(posedge SClk) begin
        if (reset) begin
            state <= mapper_pkg::wait_aa;
        end else if (mem_wr && psram_hit) begin
            case (state)
                mapper_pkg::wait_aa:
                    if (wr_data == mapper_pkg::FLASH_KEY1) state <= mapper_pkg::wait_55;
                mapper_pkg::wait_55:
                    state <= (wr_data == mapper_pkg::FLASH_KEY2) ?
                             mapper_pkg::cmd : mapper_pkg::wait_aa;
                mapper_pkg::cmd: begin
                    case (wr_data)
                        mapper_pkg::FLASH_CMD_FAST:    state <= mapper_pkg::fast_mode;
                        mapper_pkg::FLASH_CMD_PROGRAM: state <= mapper_pkg::single_write;
                        mapper_pkg::FLASH_CMD_ERASE_CHIP,
                        mapper_pkg::FLASH_CMD_ERASE_SECTOR: state <= mapper_pkg::erase;
                        default:                       state <= mapper_pkg::wait_aa;
                    endcase
                end
                mapper_pkg::fast_mode: begin
                    if (wr_data == mapper_pkg::FLASH_CMD_PROGRAM) begin
                        state <= mapper_pkg::fast_write;
                    end else if (wr_data == mapper_pkg::FLASH_CMD_EXIT_FAST) begin
                        state <= mapper_pkg::wait_aa;
                    end
                end
                mapper_pkg::fast_write:   state <= mapper_pkg::fast_mode;
                mapper_pkg::single_write: state <= mapper_pkg::wait_aa;
                // a new unlock can start straight from erase
                default:
                    state <= (wr_data == mapper_pkg::FLASH_KEY1) ?
                             mapper_pkg::wait_55 : mapper_pkg::wait_aa;
            endcase
        end
    end

    assign pass_read  = ~flash_emu_enable |
                        (state != mapper_pkg::erase && state != mapper_pkg::fast_mode);
    assign pass_write = ~flash_emu_enable |
                        (state == mapper_pkg::single_write || state == mapper_pkg::fast_write);
    assign catch_read = ~pass_read & psram_hit;
    assign status     = (state == mapper_pkg::erase) ?
                        mapper_pkg::FLASH_ERASE_STATUS : mapper_pkg::FLASH_FAST_STATUS;

    a_reset_state: assert property (@(posedge SClk)
        reset |=> state == mapper_pkg::wait_aa);

endmodule

//--- design/addr_decode.sv
module addr_decode (
    input  mapper_pkg::byte_t     linear_bank,
    input  mapper_pkg::bank_t     ram_bank,
    input  mapper_pkg::bank_t     rom0_bank,
    input  mapper_pkg::bank_t     rom1_bank,
    input  mapper_pkg::rom_page_t rom_mask,
    input  mapper_pkg::ram_page_t ram_mask,
    input  logic                  mask_rom0,
    input  logic                  mask_rom1,
    input  logic                  mask_ram,
    input  logic                  self_flash,
    input  logic                  sram_enable,
    input  logic [3:0]            s_addr_hi,
    input  logic                  s_sel_n,
    input  logic                  s_oe_n,
    input  logic                  s_we_n,
    input  logic                  s_io_n,
    input  logic                  pass_read,
    input  logic                  pass_write,
    output logic                  psram1_hit,
    output logic                  psram2_hit,
    output mapper_pkg::addr_ext_t addr_ext,
    output logic                  psram1_sel_n,
    output logic                  psram2_sel_n,
    output logic                  sram_sel_n
);

    mapper_pkg::rom_page_t page_sel;
    mapper_pkg::rom_page_t rom_page;
    mapper_pkg::ram_page_t ram_page;
    logic rom_space;
    logic ram_space;
    logic apply_mask;
    logic sram_hit;
    logic mem_cycle;
    logic psram_go;

    always_comb begin
        page_sel   = '0;
        rom_space  = 1'b0;
        ram_space  = 1'b0;
        apply_mask = 1'b1;
        case (s_addr_hi)
            // internal area, nothing on the cartridge
            4'h0: ;
            4'h1: begin
                rom_space  = self_flash;
                ram_space  = ~self_flash;
                page_sel   = ram_bank[8:0];
                apply_mask = mask_ram;
            end
            4'h2: begin
                rom_space  = 1'b1;
                page_sel   = rom0_bank[8:0];
                apply_mask = mask_rom0;
            end
            4'h3: begin
                rom_space  = 1'b1;
                page_sel   = rom1_bank[8:0];
                apply_mask = mask_rom1;
            end
            default: begin
                rom_space = 1'b1;
                page_sel  = {linear_bank[4:0], s_addr_hi};
            end
        endcase
    end

    assign rom_page = apply_mask ? (page_sel & rom_mask) : page_sel;
    assign ram_page = apply_mask ? (ram_bank[3:0] & ram_mask) : ram_bank[3:0];

    assign psram1_hit = rom_space && rom_page[8:7] == 2'b00;
    assign psram2_hit = rom_space && rom_page[8:7] == 2'b01;
    assign sram_hit   = ram_space && !ram_page[3] && sram_enable;

    // SRAM only decodes the low three banking bits
    assign addr_ext = {rom_page[6:3], rom_space ? rom_page[2:0] : ram_page[2:0]};

    assign mem_cycle = ~s_sel_n & s_io_n;
    assign psram_go  = mem_cycle & ((~s_oe_n & pass_read) | (~s_we_n & pass_write));

    assign psram1_sel_n = ~(psram_go & psram1_hit);
    assign psram2_sel_n = ~(psram_go & psram2_hit);
    assign sram_sel_n   = ~(mem_cycle & sram_hit & (~s_oe_n | ~s_we_n));

endmodule

//--- design/bank_regs.sv
module bank_regs (
    input  logic                   SClk,
    input  logic                   reset,
    input  logic                   io_wr,
    input  mapper_pkg::reg_addr_t  wr_addr,
    input  mapper_pkg::byte_t      wr_data,
    input  mapper_pkg::reg_addr_t  s_reg_addr,
    output mapper_pkg::byte_t      linear_bank,
    output mapper_pkg::bank_t      ram_bank,
    output mapper_pkg::bank_t      rom0_bank,
    output mapper_pkg::bank_t      rom1_bank,
    output mapper_pkg::rom_page_t  rom_mask,
    output mapper_pkg::ram_page_t  ram_mask,
    output logic                   mask_rom0,
    output logic                   mask_rom1,
    output logic                   mask_ram,
    output logic                   self_flash,
    output logic                   sram_enable,
    output logic                   flash_emu_enable,
    output logic                   reg_hit,
    output mapper_pkg::byte_t      reg_data
);

    logic ext_nile;
    logic ext_2003;
    mapper_pkg::byte_t pow_cnt;

    assign pow_cnt = {1'b0, sram_enable, 1'b0, ext_2003, 1'b0, ext_nile, 2'b00};

    always_ff @(posedge SClk) begin
        if (reset) begin
            linear_bank      <= mapper_pkg::LINEAR_RESET;
            ram_bank         <= mapper_pkg::BANK_RESET;
            rom0_bank        <= mapper_pkg::BANK_RESET;
            rom1_bank        <= mapper_pkg::BANK_RESET;
            rom_mask         <= mapper_pkg::ROM_MASK_RESET;
            ram_mask         <= mapper_pkg::RAM_MASK_RESET;
            mask_rom0        <= 1'b1;
            mask_rom1        <= 1'b1;
            mask_ram         <= 1'b1;
            self_flash       <= 1'b0;
            sram_enable      <= 1'b1;
            flash_emu_enable <= 1'b0;
            ext_nile         <= 1'b1;
            ext_2003         <= 1'b1;
        end else if (io_wr) begin
            case (wr_addr)
                mapper_pkg::LINEAR_ADDR_OFF: linear_bank <= wr_data;
                mapper_pkg::RAM_BANK:        ram_bank[7:0] <= wr_data;
                mapper_pkg::ROM_BANK_0:      rom0_bank[7:0] <= wr_data;
                mapper_pkg::ROM_BANK_1:      rom1_bank[7:0] <= wr_data;
                // 2003 registers, high halves take two bits
                mapper_pkg::RAM_BANK_L:
                    if (ext_2003) ram_bank[7:0] <= wr_data;
                mapper_pkg::ROM_BANK_0_L:
                    if (ext_2003) rom0_bank[7:0] <= wr_data;
                mapper_pkg::ROM_BANK_1_L:
                    if (ext_2003) rom1_bank[7:0] <= wr_data;
                mapper_pkg::RAM_BANK_H:
                    if (ext_2003) ram_bank[9:8] <= wr_data[1:0];
                mapper_pkg::ROM_BANK_0_H:
                    if (ext_2003) rom0_bank[9:8] <= wr_data[1:0];
                mapper_pkg::ROM_BANK_1_H:
                    if (ext_2003) rom1_bank[9:8] <= wr_data[1:0];
                mapper_pkg::MEMORY_CTRL:
                    if (ext_2003) self_flash <= wr_data[0];
                mapper_pkg::BANK_MASK_LO:
                    if (ext_nile) rom_mask[7:0] <= wr_data;
                mapper_pkg::BANK_MASK_HI: begin
                    if (ext_nile) begin
                        rom_mask[8] <= wr_data[0];
                        mask_rom0   <= wr_data[1];
                        mask_rom1   <= wr_data[2];
                        mask_ram    <= wr_data[3];
                        ram_mask    <= wr_data[7:4];
                    end
                end
                mapper_pkg::POW_CNT: begin
                    // unlock value lets software recover the extension
                    if (ext_nile || wr_data == mapper_pkg::POW_UNLOCK) begin
                        ext_nile    <= wr_data[2];
                        ext_2003    <= wr_data[4];
                        sram_enable <= wr_data[6];
                    end
                end
                mapper_pkg::EMU_CNT:
                    if (ext_nile) flash_emu_enable <= wr_data[2];
                default: ;
            endcase
        end
    end

    always_comb begin
        reg_hit  = 1'b1;
        reg_data = '0;
        case (s_reg_addr)
            mapper_pkg::LINEAR_ADDR_OFF: reg_data = linear_bank;
            mapper_pkg::RAM_BANK, mapper_pkg::RAM_BANK_L:
                reg_data = ram_bank[7:0];
            mapper_pkg::ROM_BANK_0, mapper_pkg::ROM_BANK_0_L:
                reg_data = rom0_bank[7:0];
            mapper_pkg::ROM_BANK_1, mapper_pkg::ROM_BANK_1_L:
                reg_data = rom1_bank[7:0];
            mapper_pkg::RAM_BANK_H:   reg_data = {6'h00, ram_bank[9:8]};
            mapper_pkg::ROM_BANK_0_H: reg_data = {6'h00, rom0_bank[9:8]};
            mapper_pkg::ROM_BANK_1_H: reg_data = {6'h00, rom1_bank[9:8]};
            mapper_pkg::MEMORY_CTRL:  reg_data = {7'h00, self_flash};
            mapper_pkg::POW_CNT:      reg_data = pow_cnt;
            mapper_pkg::BANK_MASK_LO: reg_data = rom_mask[7:0];
            mapper_pkg::BANK_MASK_HI:
                reg_data = {ram_mask, mask_ram, mask_rom1, mask_rom0, rom_mask[8]};
            mapper_pkg::EMU_CNT:      reg_data = {5'h00, flash_emu_enable, 2'b00};
            default:                  reg_hit = 1'b0;
        endcase
    end

endmodule

//--- design/bus_sampler.sv
module bus_sampler (
    input  logic                  SClk,
    input  logic                  reset,
    input  logic                  sel_n,
    input  logic                  oe_n,
    input  logic                  we_n,
    input  logic                  io_n,
    input  logic [3:0]            addr_hi,
    input  logic [3:0]            addr_lo,
    input  mapper_pkg::byte_t     data_in,
    output logic                  s_sel_n,
    output logic                  s_oe_n,
    output logic                  s_we_n,
    output logic                  s_io_n,
    output mapper_pkg::reg_addr_t s_reg_addr,
    output logic [3:0]            s_addr_hi,
    output mapper_pkg::byte_t     s_data,
    output logic                  io_wr,
    output logic                  mem_wr,
    output mapper_pkg::reg_addr_t wr_addr,
    output mapper_pkg::byte_t     wr_data
);

    logic write_end;

    // we_n rising while the cartridge was selected in the last sample
    assign write_end = ~s_we_n & we_n & ~s_sel_n;
    assign s_addr_hi = s_reg_addr[7:4];

    always_ff @(posedge SClk) begin
        if (reset) begin
            s_sel_n <= 1'b1;
            s_oe_n  <= 1'b1;
            s_we_n  <= 1'b1;
            s_io_n  <= 1'b1;
            io_wr   <= 1'b0;
            mem_wr  <= 1'b0;
        end else begin
            s_sel_n <= sel_n;
            s_oe_n  <= oe_n;
            s_we_n  <= we_n;
            s_io_n  <= io_n;
            io_wr   <= write_end & ~s_io_n;
            mem_wr  <= write_end & s_io_n;
        end
    end

    always_ff @(posedge SClk) begin
        s_reg_addr <= {addr_hi, addr_lo};
        s_data     <= data_in;
        // keeps the last sample taken while we_n was low
        if (!s_we_n) begin
            wr_addr <= s_reg_addr;
            wr_data <= s_data;
        end
    end

    a_wr_exclusive: assert property (@(posedge SClk) disable iff (reset)
        !(io_wr && mem_wr));

endmodule

//--- design/mapper_pkg.sv
package mapper_pkg;

    // widths that carry a meaning on the cartridge side
    typedef logic [7:0] byte_t;
    typedef logic [7:0] reg_addr_t;
    typedef logic [9:0] bank_t;
    typedef logic [8:0] rom_page_t;
    typedef logic [3:0] ram_page_t;
    typedef logic [6:0] addr_ext_t;

    typedef enum logic [2:0] {
        wait_aa,
        wait_55,
        cmd,
        fast_mode,
        fast_write,
        single_write,
        erase
    } flash_state_t;

    // bandai 2001 bank registers
    localparam reg_addr_t LINEAR_ADDR_OFF = 8'hC0;
    localparam reg_addr_t RAM_BANK        = 8'hC1;
    localparam reg_addr_t ROM_BANK_0      = 8'hC2;
    localparam reg_addr_t ROM_BANK_1      = 8'hC3;

    // bandai 2003 registers
    localparam reg_addr_t MEMORY_CTRL  = 8'hCE;
    localparam reg_addr_t RAM_BANK_L   = 8'hD0;
    localparam reg_addr_t RAM_BANK_H   = 8'hD1;
    localparam reg_addr_t ROM_BANK_0_L = 8'hD2;
    localparam reg_addr_t ROM_BANK_0_H = 8'hD3;
    localparam reg_addr_t ROM_BANK_1_L = 8'hD4;
    localparam reg_addr_t ROM_BANK_1_H = 8'hD5;

    // nileswan extension
    localparam reg_addr_t POW_CNT      = 8'hE2;
    localparam reg_addr_t BANK_MASK_LO = 8'hE4;
    localparam reg_addr_t BANK_MASK_HI = 8'hE5;
    localparam reg_addr_t EMU_CNT      = 8'hE6;

    // POW_CNT accepts this value even with the extension off
    localparam byte_t POW_UNLOCK = 8'hFD;

    localparam bank_t     BANK_RESET     = 10'h3FF;
    localparam byte_t     LINEAR_RESET   = 8'hFF;
    localparam rom_page_t ROM_MASK_RESET = 9'h1FF;
    localparam ram_page_t RAM_MASK_RESET = 4'hF;

    localparam byte_t FLASH_KEY1             = 8'hAA;
    localparam byte_t FLASH_KEY2             = 8'h55;
    localparam byte_t FLASH_CMD_FAST         = 8'h20;
    localparam byte_t FLASH_CMD_PROGRAM      = 8'hA0;
    localparam byte_t FLASH_CMD_ERASE_SECTOR = 8'h30;
    localparam byte_t FLASH_CMD_ERASE_CHIP   = 8'h10;
    localparam byte_t FLASH_CMD_EXIT_FAST    = 8'h90;

    localparam byte_t FLASH_ERASE_STATUS = 8'hFF;
    localparam byte_t FLASH_FAST_STATUS  = 8'h00;

endpackage
